//--- source/mulDivPkg.sv
/* Shared types for the multiply/divide unit: word size, request opcodes,
   divider FSM states and the request and HI/LO result structs. */
`default_nettype none

package mulDivPkg;

	localparam int dataWidth = 32; // fixed by the instruction set

	typedef enum logic [2:0] {
		MD_NONE,
		MD_MULT,
		MD_MULTU,
		MD_DIV,
		MD_DIVU,
		MD_MTHI,
		MD_MTLO
	} mdOp;

	typedef enum logic [1:0] {
		DIV_FREE,
		DIV_BY_ZERO,
		DIV_ON,
		DIV_END
	} divState;

	typedef struct packed {
		mdOp                  op;
		logic [dataWidth-1:0] opA;
		logic [dataWidth-1:0] opB;
	} mdRequest;

	typedef struct packed {
		logic [dataWidth-1:0] hi; // remainder for divides
		logic [dataWidth-1:0] lo; // quotient for divides
	} hiLoPair;

endpackage

`default_nettype wire

//--- source/divider.sv
/* Restoring radix-2 divider, one quotient bit per cycle. Hold start until
   ready rises, then drop it; abandon returns the FSM to idle at once. */
`timescale 1ns/100ps
`default_nettype none

module divider import mulDivPkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 start,
	input  wire logic                 abandon,
	input  wire logic                 signedDiv,
	input  wire logic [dataWidth-1:0] dividend,
	input  wire logic [dataWidth-1:0] divisor,
	output logic                      ready,
	output hiLoPair                   result
);

	localparam int cntWidth = $clog2(dataWidth) + 1;

	divState              state;
	logic [cntWidth-1:0]  cnt;
	logic [2*dataWidth:0] shiftReg; // remainder above, quotient below
	logic [dataWidth-1:0] divisorReg;
	logic [dataWidth-1:0] magA;
	logic [dataWidth-1:0] magB;
	logic [dataWidth+1:0] diff;
	logic                 negQuot;
	logic                 negRem;
	logic                 lastStep;

	assign magA = (signedDiv && dividend[dataWidth-1]) ? -dividend : dividend;
	assign magB = (signedDiv && divisor[dataWidth-1]) ? -divisor : divisor;

	// trial subtraction, one bit wider than the partial remainder
	assign diff = {1'b0, shiftReg[2*dataWidth:dataWidth]} - {2'b0, divisorReg};

	assign negQuot  = signedDiv && (dividend[dataWidth-1] ^ divisor[dataWidth-1]);
	assign negRem   = signedDiv && dividend[dataWidth-1]; // remainder follows dividend
	assign lastStep = (cnt == cntWidth'(dataWidth));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= DIV_FREE;
			cnt   <= '0;
			ready <= 1'b0;
		end else if (abandon) begin
			state <= DIV_FREE;
			cnt   <= '0;
			ready <= 1'b0;
		end else begin
			case (state)
				DIV_FREE: begin
					ready <= 1'b0;
					if (start) begin
						cnt   <= '0;
						state <= (divisor == '0) ? DIV_BY_ZERO : DIV_ON;
					end
				end
				DIV_BY_ZERO: state <= DIV_END;
				DIV_ON: begin
					if (!lastStep) begin
						cnt <= cnt + 1'b1;
					end else begin
						cnt   <= '0;
						state <= DIV_END; // sign fix happens on this cycle
					end
				end
				DIV_END: begin
					ready <= 1'b1;
					if (!start) begin
						state <= DIV_FREE;
						ready <= 1'b0;
					end
				end
				default: state <= DIV_FREE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			DIV_FREE: begin
				shiftReg   <= {{dataWidth{1'b0}}, magA, 1'b0};
				divisorReg <= magB;
			end
			DIV_BY_ZERO: shiftReg <= '0;
			DIV_ON: begin
				if (!lastStep) begin
					if (diff[dataWidth+1]) // negative, restore
						shiftReg <= {shiftReg[2*dataWidth-1:0], 1'b0};
					else
						shiftReg <= {diff[dataWidth-1:0], shiftReg[dataWidth-1:0], 1'b1};
				end else begin
					if (negQuot)
						shiftReg[dataWidth-1:0] <= -shiftReg[dataWidth-1:0];
					if (negRem)
						shiftReg[2*dataWidth:dataWidth+1] <= -shiftReg[2*dataWidth:dataWidth+1];
				end
			end
			DIV_END: begin
				result.hi <= shiftReg[2*dataWidth:dataWidth+1];
				result.lo <= shiftReg[dataWidth-1:0];
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- source/multiplier.sv
/* Pipelined 32x32 multiplier, signed or unsigned per request.
   The product appears mulStages cycles after inValid; flush drops all in flight. */
`timescale 1ns/100ps
`default_nettype none

module multiplier import mulDivPkg::*; #(
	parameter int mulStages = 2
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 inValid,
	input  wire logic                 signedMul,
	input  wire logic [dataWidth-1:0] opA,
	input  wire logic [dataWidth-1:0] opB,
	input  wire logic                 flush,
	output logic                      outValid,
	output hiLoPair                   product
);

	logic signed [dataWidth:0]       extA;
	logic signed [dataWidth:0]       extB;
	logic signed [2*dataWidth+1:0]   fullProd;
	logic        [mulStages-1:0]     validPipe;
	hiLoPair                         prodPipe [mulStages];

	// one extra bit makes a single signed multiply cover both modes
	assign extA = {signedMul & opA[dataWidth-1], opA};
	assign extB = {signedMul & opB[dataWidth-1], opB};
	assign fullProd = extA * extB;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			validPipe <= '0;
		end else if (flush) begin
			validPipe <= '0;
		end else begin
			validPipe[0] <= inValid;
			for (int i = 1; i < mulStages; i++)
				validPipe[i] <= validPipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		prodPipe[0] <= hiLoPair'(fullProd[2*dataWidth-1:0]);
		for (int i = 1; i < mulStages; i++)
			prodPipe[i] <= prodPipe[i-1];
	end

	assign outValid = validPipe[mulStages-1];
	assign product  = prodPipe[mulStages-1];

endmodule

`default_nettype wire

//--- source/hiLoRegs.sv
/* HI/LO register pair. Engine results load both halves at once;
   MTHI and MTLO load one half from moveData. */
`timescale 1ns/100ps
`default_nettype none

module hiLoRegs import mulDivPkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 resultWe,
	input  wire hiLoPair              result,
	input  wire logic                 hiWe,
	input  wire logic                 loWe,
	input  wire logic [dataWidth-1:0] moveData,
	output hiLoPair                   hiLo
);

	hiLoPair regs;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			regs <= '0;
		end else if (resultWe) begin
			regs <= result; // multiply or divide writes both
		end else begin
			if (hiWe)
				regs.hi <= moveData;
			if (loWe)
				regs.lo <= moveData;
		end
	end

	assign hiLo = regs;

endmodule

`default_nettype wire

//--- source/mulDivUnit.sv
/* Multiply/divide unit top level. Decodes requests from the core, runs the
   multiplier or divider, writes HI/LO and holds busy until a result lands. */
`timescale 1ns/100ps
`default_nettype none

module mulDivUnit import mulDivPkg::*; #(
	parameter int mulStages = 2
) (
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire mdRequest request,
	input  wire logic     reqValid,
	input  wire logic     flush,
	output logic          busy,
	output hiLoPair       hiLo
);

	logic                 accept;
	logic                 startMul;
	logic                 startDiv;
	logic                 mulOutValid;
	hiLoPair              mulProduct;
	logic                 divStart;
	logic                 divReady;
	logic                 divDone;
	hiLoPair              divResult;
	logic [dataWidth-1:0] divA;
	logic [dataWidth-1:0] divB;
	logic                 divSigned;
	logic                 resultWe;
	hiLoPair              resultData;
	logic                 hiWe;
	logic                 loWe;

	assign accept   = reqValid && !busy; // requests during busy are dropped
	assign startMul = accept && (request.op == MD_MULT || request.op == MD_MULTU);
	assign startDiv = accept && (request.op == MD_DIV || request.op == MD_DIVU);
	assign hiWe     = accept && (request.op == MD_MTHI);
	assign loWe     = accept && (request.op == MD_MTLO);

	assign divDone    = divStart && divReady; // first ready cycle only
	assign resultWe   = (mulOutValid || divDone) && !flush;
	assign resultData = mulOutValid ? mulProduct : divResult;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy     <= 1'b0;
			divStart <= 1'b0;
		end else if (flush) begin
			busy     <= 1'b0;
			divStart <= 1'b0;
		end else begin
			if (startMul || startDiv)
				busy <= 1'b1;
			else if (resultWe)
				busy <= 1'b0;
			if (startDiv)
				divStart <= 1'b1;
			else if (divDone)
				divStart <= 1'b0;
		end
	end

	// divider reads its operands for the whole run
	always_ff @(posedge clk) begin
		if (startDiv) begin
			divA      <= request.opA;
			divB      <= request.opB;
			divSigned <= (request.op == MD_DIV);
		end
	end

	multiplier #(.mulStages(mulStages)) mul (
		.clk       (clk),
		.rst       (rst),
		.inValid   (startMul),
		.signedMul (request.op == MD_MULT),
		.opA       (request.opA),
		.opB       (request.opB),
		.flush     (flush),
		.outValid  (mulOutValid),
		.product   (mulProduct)
	);

	divider div (
		.clk       (clk),
		.rst       (rst),
		.start     (divStart),
		.abandon   (flush),
		.signedDiv (divSigned),
		.dividend  (divA),
		.divisor   (divB),
		.ready     (divReady),
		.result    (divResult)
	);

	hiLoRegs regs (
		.clk      (clk),
		.rst      (rst),
		.resultWe (resultWe),
		.result   (resultData),
		.hiWe     (hiWe),
		.loWe     (loWe),
		.moveData (request.opA),
		.hiLo     (hiLo)
	);

endmodule

`default_nettype wire

//--- test/mulDivUnit_assertions.sv
/* Concurrent checks on busy, the request strobe, flush and divider ready.
   Bound into every mulDivUnit instance. */
`timescale 1ns/100ps
`default_nettype none

module mulDivUnitAssertions import mulDivPkg::*; (
	input wire logic    clk,
	input wire logic    rst,
	input wire logic    reqValid,
	input wire logic    flush,
	input wire logic    busy,
	input wire logic    divReady,
	input wire divState divFsm
);

	int failCount = 0; // read by the testbench

	idleAfterReset: assert property (@(posedge clk) $fell(rst) |-> !busy)
	else begin
		failCount++;
		$error("busy is high right after reset release");
	end

	noRequestWhileBusy: assert property (@(posedge clk) disable iff (rst) !(reqValid && busy))
	else begin
		failCount++;
		$error("request strobe while the unit is busy");
	end

	// ready only comes out of the end state
	readyOnlyAtEnd: assert property (@(posedge clk) disable iff (rst)
		divReady |-> (divFsm == DIV_END))
	else begin
		failCount++;
		$error("divider ready outside DIV_END");
	end

	flushClearsBusy: assert property (@(posedge clk) disable iff (rst) flush |=> !busy)
	else begin
		failCount++;
		$error("busy still high after a flush");
	end

endmodule

bind mulDivUnit mulDivUnitAssertions protocolChecks (
	.clk      (clk),
	.rst      (rst),
	.reqValid (reqValid),
	.flush    (flush),
	.busy     (busy),
	.divReady (divReady),
	.divFsm   (div.state)
);

`default_nettype wire

//--- test/mulDivUnitTb.sv
/* Testbench for the multiply/divide unit. Runs multiplies, divides, moves and
   flushes through the top level and compares HI/LO with a reference model. */
`timescale 1ns/100ps
`default_nettype none

module mulDivUnitTb import mulDivPkg::*; ();

	localparam int clkPeriod   = 40;
	localparam int numCorners  = 7;
	localparam int numRounds   = 10;
	localparam int numRequests = numCorners * 4 + numRounds * 4 + 14;

	localparam logic [dataWidth-1:0] cornerA [numCorners] = '{
		32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'hffff_fff9,
		32'd100, 32'h1234_5678, 32'h7fff_ffff
	};
	localparam logic [dataWidth-1:0] cornerB [numCorners] = '{
		32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000, 32'd2,
		32'hffff_fffd, 32'd0, 32'd1
	};
	localparam mdOp mathOps [4] = '{MD_MULT, MD_MULTU, MD_DIV, MD_DIVU};

	logic     clk = 1'b0;
	logic     rst;
	mdRequest request;
	logic     reqValid;
	logic     flush;
	logic     busy;
	hiLoPair  hiLo;

	hiLoPair              expected; // model of HI/LO
	string                testName;
	logic                 pending;
	logic [dataWidth-1:0] rngState;

	mulDivUnit #(.mulStages(2)) DUT (
		.clk      (clk),
		.rst      (rst),
		.request  (request),
		.reqValid (reqValid),
		.flush    (flush),
		.busy     (busy),
		.hiLo     (hiLo)
	);

	always #(clkPeriod / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic hiLoPair expectHiLo(input mdOp op, input logic [dataWidth-1:0] a,
			input logic [dataWidth-1:0] b, input hiLoPair prev);
		longint  sa;
		longint  sb;
		longint  q;
		longint  r;
		hiLoPair res;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		res = prev;
		case (op)
			MD_MULT:  res = hiLoPair'(sa * sb);
			MD_MULTU: res = hiLoPair'({32'b0, a} * {32'b0, b});
			MD_DIV, MD_DIVU: begin
				if (b == '0) begin
					res = '0;
				end else begin
					if (op == MD_DIVU) begin
						sa = longint'({32'b0, a});
						sb = longint'({32'b0, b});
					end
					q = sa / sb; // truncates toward zero
					r = sa % sb; // sign of the dividend
					res.hi = r[31:0];
					res.lo = q[31:0];
				end
			end
			MD_MTHI:  res.hi = a;
			MD_MTLO:  res.lo = a;
			default:  ;
		endcase
		return res;
	endfunction

	task automatic stopOnFailure(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [63:0] expectedValue,
			input logic [63:0] actualValue);
		if (actualValue !== expectedValue)
			stopOnFailure($sformatf("[FAIL] %s: expected %h, actual %h",
				name, expectedValue, actualValue));
	endtask

	// called 5 ns after an edge, returns 5 ns after the accepting edge
	task automatic sendRequest(input mdOp op, input logic [dataWidth-1:0] a,
			input logic [dataWidth-1:0] b);
		request.op  = op;
		request.opA = a;
		request.opB = b;
		reqValid    = 1'b1;
		@(posedge clk);
		#5;
		reqValid   = 1'b0;
		request.op = MD_NONE;
	endtask

	task automatic runRequest(input mdOp op, input logic [dataWidth-1:0] a,
			input logic [dataWidth-1:0] b, input string name);
		sendRequest(op, a, b);
		expected = expectHiLo(op, a, b, expected);
		testName = name;
		pending  = 1'b1;
		wait (!pending);
	endtask

	task automatic runFlushed(input mdOp op, input logic [dataWidth-1:0] a,
			input logic [dataWidth-1:0] b, input int delay, input string name);
		sendRequest(op, a, b);
		repeat (delay - 1) begin
			@(posedge clk);
			#5;
		end
		flush = 1'b1;
		@(posedge clk);
		#5;
		flush = 1'b0;
		repeat (2) begin // a product left in the pipeline would land here
			@(posedge clk);
			#5;
		end
		testName = name; // HI/LO must keep the old value
		pending  = 1'b1;
		wait (!pending);
	endtask

	// compare once the unit goes idle
	always begin
		wait (pending);
		while (busy) begin
			@(posedge clk);
			#5;
		end
		checkValue(testName, expected, hiLo);
		pending = 1'b0;
	end

	always @(negedge clk) begin
		if (DUT.protocolChecks.failCount != 0)
			stopOnFailure("a protocol assertion fired inside the DUT");
	end

	initial begin
		repeat (numRequests * 40 + 100) @(posedge clk);
		stopOnFailure("watchdog expired, a request never finished");
	end

	initial begin
		mdOp                  op;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		rst      = 1'b1;
		reqValid = 1'b0;
		flush    = 1'b0;
		request  = '0;
		expected = '0;
		pending  = 1'b0;
		testName = "";
		rngState = 32'h38d481ee;
		repeat (3) @(posedge clk);
		#5;
		rst = 1'b0;
		checkValue("reset busy", 64'd0, 64'(busy));
		checkValue("reset hiLo", 64'd0, hiLo);

		for (int i = 0; i < numCorners; i++) begin
			for (int j = 0; j < 4; j++) begin
				op = mathOps[j];
				runRequest(op, cornerA[i], cornerB[i], $sformatf("%s corner %0d", op.name(), i));
			end
		end

		for (int i = 0; i < numRounds; i++) begin
			for (int j = 0; j < 4; j++) begin
				rngState = xorshift(rngState);
				a = rngState;
				rngState = xorshift(rngState);
				b = rngState >> rngState[4:0]; // small divisors now and then
				op = mathOps[j];
				runRequest(op, a, b, $sformatf("%s random %0d", op.name(), i));
			end
		end

		runRequest(MD_MTHI, 32'hcafe_0001, 32'h0, "mthi");
		runRequest(MD_MTLO, 32'h0bad_f00d, 32'h0, "mtlo");
		runRequest(MD_MULT, 32'hffff_fffd, 32'd5, "mult after moves");
		runRequest(MD_MTLO, 32'h5555_aaaa, 32'h0, "mtlo again");
		runRequest(MD_MTHI, 32'h1357_9bdf, 32'h0, "mthi again");
		runRequest(MD_DIVU, 32'd100, 32'd7, "divu after moves");

		runFlushed(MD_DIV, 32'h8000_0001, 32'd3, 5, "div flushed");
		runRequest(MD_DIV, 32'hffff_fc18, 32'd7, "div after flush");
		runFlushed(MD_MULT, 32'h1234_5678, 32'h9abc_def0, 1, "mult flushed");
		runRequest(MD_MULTU, 32'hdead_beef, 32'h0000_0100, "multu after flush");
		runFlushed(MD_MULTU, 32'hffff_ffff, 32'h7777_7777, 2, "multu flushed late");
		runRequest(MD_DIVU, 32'hffff_ffff, 32'd10, "divu after flush");
		runFlushed(MD_DIVU, 32'h0f0f_0f0f, 32'd9, 20, "divu flushed");
		runRequest(MD_MULT, 32'h8000_0000, 32'd3, "mult after divu flush");

		@(negedge clk);
		if (DUT.protocolChecks.failCount != 0) begin
			stopOnFailure("a protocol assertion fired during the run");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim.f
source/mulDivPkg.sv
source/divider.sv
source/multiplier.sv
source/hiLoRegs.sv
source/mulDivUnit.sv
test/mulDivUnit_assertions.sv
test/mulDivUnitTb.sv
